// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = memcpy_kernel_tb
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: dv/memcpy_kernel_assert.sv
`timescale 1ns/10ps

module memcpy_kernel_assert import memcpy_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input burst_cmd_t o_ar,
    input logic       o_ar_valid,
    input logic       i_ar_ready,
    input burst_cmd_t o_aw,
    input logic       o_aw_valid,
    input logic       i_aw_ready,
    input beat_t      o_w,
    input logic       o_w_valid,
    input logic       i_w_ready
);

    logic [BLEN_W-1:0] aw_lens [16];
    logic [3:0]        aw_wr;
    logic [3:0]        aw_rd;
    logic [BLEN_W-1:0] w_beat;

    // lengths of accepted write bursts, matched against beats
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_wr  <= '0;
            aw_rd  <= '0;
            w_beat <= '0;
        end else begin
            if (o_aw_valid && i_aw_ready) begin
                aw_lens[aw_wr] <= o_aw.len;
                aw_wr          <= aw_wr + 1'b1;
            end
            if (o_w_valid && i_w_ready) begin
                w_beat <= o_w.last ? '0 : w_beat + 1'b1;
                if (o_w.last) begin
                    aw_rd <= aw_rd + 1'b1;
                end
            end
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_ar_valid && !i_ar_ready |=> o_ar_valid && $stable(o_ar)) else $error("ar dropped");
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_aw_valid && !i_aw_ready |=> o_aw_valid && $stable(o_aw)) else $error("aw dropped");
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_w_valid && !i_w_ready |=> o_w_valid && $stable(o_w)) else $error("w dropped");
    quiet_reset: assert property (@(posedge clk)
        !rst_n |-> !o_ar_valid && !o_aw_valid && !o_w_valid) else $error("valid in reset");
    w_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        o_w_valid && i_w_ready && o_w.last |-> aw_wr != aw_rd && w_beat == aw_lens[aw_rd])
        else $error("write burst beat count differs from aw length");

endmodule

bind memcpy_kernel memcpy_kernel_assert memcpy_kernel_assert_i (.*);

// File: dv/memcpy_kernel_tb.sv
`timescale 1ns/10ps

module memcpy_kernel_tb import memcpy_pkg::*; ();

    // eight starts of at most a few hundred cycles each under stalls
    localparam int TIMEOUT_CYCLES = 20000;

    logic                  clk;
    logic                  rst_n;
    reg_req_t              i_reg;
    logic [REG_DATA_W-1:0] o_reg_rdata;
    logic                  i_run_mode;
    logic                  i_start;
    logic [SYS_W-1:0]      i_system_register;
    logic                  o_complete;
    burst_cmd_t            o_ar;
    logic                  o_ar_valid;
    logic                  i_ar_ready;
    beat_t                 i_r;
    logic                  i_r_valid;
    logic                  o_r_ready;
    burst_cmd_t            o_aw;
    logic                  o_aw_valid;
    logic                  i_aw_ready;
    beat_t                 o_w;
    logic                  o_w_valid;
    logic                  i_w_ready;
    logic                  i_b_valid;
    logic                  o_b_ready;

    integer      seed = 32'h4633_c239;
    int          stall_pct;
    int          cycles;
    int          data_errs;
    int          burst_errs;
    int          reg_errs;
    logic        check_req;
    logic [63:0] cur_src;
    logic [63:0] cur_dst;
    logic [31:0] cur_len;

    // host memory, keyed by byte address of each word
    logic [63:0] mem [logic [63:0]];
    logic [63:0] old_mem [logic [63:0]];
    logic [63:0] rq_addr [$];
    logic        rq_last [$];
    logic [63:0] wq_addr [$];
    int          wq_left [$];
    int          b_pend;
    logic [63:0] log_ar_addr [$];
    int          log_ar_beats [$];
    logic [63:0] log_aw_addr [$];
    int          log_aw_beats [$];

    memcpy_kernel memcpy_kernel_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [63:0] fill_word(input logic [63:0] a);
        return {a[31:0], ~a[63:32]} ^ 64'h5bd1_e995_0c3f_a7d2;
    endfunction

    function automatic logic [63:0] read_word(input logic [63:0] a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    function automatic logic [63:0] old_word(input logic [63:0] a);
        return old_mem.exists(a) ? old_mem[a] : fill_word(a);
    endfunction

    // what a word must hold after the current job
    function automatic logic [63:0] expected_word(input logic [63:0] a);
        if (a >= cur_dst && a < cur_dst + 64'(cur_len)) begin
            return old_word(cur_src + (a - cur_dst));
        end
        return old_word(a);
    endfunction

    function automatic logic ready_roll();
        return ($unsigned($random(seed)) % 100) >= stall_pct;
    endfunction

    // host memory model on the five channels
    always @(posedge clk) begin : host_model
        int n;
        if (!rst_n) begin
            i_ar_ready <= 1'b0;
            i_aw_ready <= 1'b0;
            i_w_ready  <= 1'b0;
            i_r_valid  <= 1'b0;
            i_b_valid  <= 1'b0;
            b_pend = 0;
        end else begin
            if (o_ar_valid && i_ar_ready) begin
                log_ar_addr.push_back(o_ar.addr);
                log_ar_beats.push_back(int'(o_ar.len) + 1);
                for (n = 0; n <= int'(o_ar.len); n++) begin
                    rq_addr.push_back(o_ar.addr + 64'(n * 8));
                    rq_last.push_back(n == int'(o_ar.len));
                end
            end
            if (i_r_valid && o_r_ready) begin
                void'(rq_addr.pop_front());
                void'(rq_last.pop_front());
            end
            // a raised beat stays until taken
            if (!i_r_valid || o_r_ready) begin
                if (rq_addr.size() > 0 && ready_roll()) begin
                    i_r_valid <= 1'b1;
                    i_r       <= '{data: read_word(rq_addr[0]), last: rq_last[0]};
                end else begin
                    i_r_valid <= 1'b0;
                end
            end
            if (o_aw_valid && i_aw_ready) begin
                log_aw_addr.push_back(o_aw.addr);
                log_aw_beats.push_back(int'(o_aw.len) + 1);
                wq_addr.push_back(o_aw.addr);
                wq_left.push_back(int'(o_aw.len) + 1);
            end
            if (o_w_valid && i_w_ready) begin
                assert (o_w.last == (wq_left[0] == 1)) else begin
                    $display("Mismatch o_w.last at %h: expected %h actual %h",
                             wq_addr[0], (wq_left[0] == 1), o_w.last);
                    burst_errs++;
                end
                mem[wq_addr[0]] = o_w.data;
                wq_addr[0] = wq_addr[0] + 64'd8;
                wq_left[0] = wq_left[0] - 1;
                if (wq_left[0] == 0) begin
                    void'(wq_addr.pop_front());
                    void'(wq_left.pop_front());
                    b_pend++;
                end
            end
            // every response must be taken when offered
            if (i_b_valid) begin
                assert (o_b_ready) else begin
                    $display("Mismatch o_b_ready: expected %h actual %h", 1'b1, o_b_ready);
                    burst_errs++;
                end
            end
            i_ar_ready <= ready_roll();
            i_aw_ready <= ready_roll();
            i_w_ready  <= (wq_addr.size() > 0) && ready_roll();
            if (b_pend > 0 && ready_roll()) begin
                i_b_valid <= 1'b1;
                b_pend--;
            end else begin
                i_b_valid <= 1'b0;
            end
        end
    end

    // compares the target range and its neighbours against the reference
    always @(posedge clk) begin : compare_words
        logic [63:0] a;
        if (check_req) begin
            for (a = cur_dst - 64'd8; a <= cur_dst + 64'(cur_len); a += 64'd8) begin
                assert (read_word(a) == expected_word(a)) else begin
                    $display("Mismatch mem[%h]: expected %h actual %h",
                             a, expected_word(a), read_word(a));
                    data_errs++;
                end
            end
            check_req = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT did not finish within %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic reg_write(input logic [REG_ADDR_W-1:0] idx, input logic [31:0] data);
        @(posedge clk);
        i_reg <= '{wr: 1'b1, rd: 1'b0, idx: idx, wdata: data};
        @(posedge clk);
        i_reg <= '0;
    endtask

    task automatic reg_check(input logic [REG_ADDR_W-1:0] idx, input logic [31:0] exp);
        @(posedge clk);
        i_reg <= '{wr: 1'b0, rd: 1'b1, idx: idx, wdata: '0};
        @(posedge clk);
        i_reg <= '0;
        @(negedge clk);
        assert (o_reg_rdata == exp) else begin
            $display("Mismatch o_reg_rdata[%0d]: expected %h actual %h", idx, exp, o_reg_rdata);
            reg_errs++;
        end
    endtask

    task automatic wait_complete();
        do @(posedge clk); while (!o_complete);
    endtask

    task automatic compare_memory();
        check_req = 1'b1;
        while (check_req) @(posedge clk);
    endtask

    task automatic start_job(input logic [63:0] src, input logic [63:0] dst, input int beats);
        old_mem = mem;
        cur_src = src;
        cur_dst = dst;
        cur_len = 32'(beats * 8);
        log_ar_addr.delete();
        log_ar_beats.delete();
        log_aw_addr.delete();
        log_aw_beats.delete();
    endtask

    task automatic check_bursts(input logic [63:0] base, input int beats,
                                ref logic [63:0] addrs[$], ref int lens[$]);
        logic [63:0] a;
        int          total;
        a = base;
        total = 0;
        foreach (addrs[i]) begin
            assert (addrs[i] == a) else begin
                $display("Mismatch burst addr: expected %h actual %h", a, addrs[i]);
                burst_errs++;
            end
            assert (lens[i] >= 1 && lens[i] <= MAX_BEATS) else begin
                $display("burst %0d has %0d beats, outside 1 to 16", i, lens[i]);
                burst_errs++;
            end
            a = addrs[i] + 64'(lens[i] * 8);
            total += lens[i];
        end
        assert (total == beats) else begin
            $display("Mismatch burst beat sum: expected %h actual %h", beats, total);
            burst_errs++;
        end
    endtask

    task automatic run_reg_job(input logic [63:0] src, input logic [63:0] dst, input int beats);
        start_job(src, dst, beats);
        reg_write(REG_SRC_LO, src[31:0]);
        reg_write(REG_SRC_HI, src[63:32]);
        reg_write(REG_DST_LO, dst[31:0]);
        reg_write(REG_DST_HI, dst[63:32]);
        reg_write(REG_LEN, cur_len);
        reg_write(REG_CTRL, 32'h1);
        wait_complete();
        compare_memory();
        check_bursts(src, beats, log_ar_addr, log_ar_beats);
        check_bursts(dst, beats, log_aw_addr, log_aw_beats);
    endtask

    initial begin
        rst_n = 1'b0;
        i_reg = '0;
        i_run_mode = 1'b0;
        i_start = 1'b0;
        i_system_register = '0;
        i_r = '0;
        i_ar_ready = 1'b0;
        i_aw_ready = 1'b0;
        i_w_ready = 1'b0;
        i_r_valid = 1'b0;
        i_b_valid = 1'b0;
        stall_pct = 0;
        cycles = 0;
        data_errs = 0;
        burst_errs = 0;
        reg_errs = 0;
        check_req = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // readback, then a 40 beat copy with status
        reg_write(REG_SRC_LO, 32'h0001_0000);
        reg_write(REG_SRC_HI, 32'h0000_0002);
        reg_write(REG_DST_LO, 32'h0003_0000);
        reg_write(REG_DST_HI, 32'h0000_0002);
        reg_write(REG_LEN, 32'd320);
        reg_check(REG_SRC_LO, 32'h0001_0000);
        reg_check(REG_SRC_HI, 32'h0000_0002);
        reg_check(REG_DST_LO, 32'h0003_0000);
        reg_check(REG_DST_HI, 32'h0000_0002);
        reg_check(REG_LEN, 32'd320);
        start_job(64'h2_0001_0000, 64'h2_0003_0000, 40);
        reg_write(REG_CTRL, 32'h1);
        reg_check(REG_STATUS, 32'h2);
        wait_complete();
        reg_check(REG_STATUS, 32'h1);
        compare_memory();

        // burst splitting
        run_reg_job(64'h1000, 64'h9000, 1);
        run_reg_job(64'h2000, 64'ha000, 16);
        run_reg_job(64'h3000, 64'hb000, 17);
        run_reg_job(64'h4000, 64'hc000, 40);

        // heavy stalls on every channel
        stall_pct = 70;
        run_reg_job(64'h5008, 64'hd010, 40);
        run_reg_job(64'h6000, 64'he000, 23);
        stall_pct = 30;

        // system mode, three repeats of a 3 burst job
        start_job(64'h4_0000, 64'h5_0000, 40);
        @(posedge clk);
        i_run_mode <= 1'b1;
        i_system_register <= '0;
        i_system_register[SYS_LEN_LSB +: 32] <= 32'd320;
        i_system_register[SYS_SRC_LSB +: 64] <= 64'h4_0000;
        i_system_register[SYS_DST_LSB +: 64] <= 64'h5_0000;
        i_system_register[SYS_CNT_LSB +: 32] <= 32'd3;
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        @(negedge clk);
        assert (!o_complete) else begin
            $display("o_complete is high while system jobs remain");
            reg_errs++;
        end
        wait_complete();
        assert (log_aw_addr.size() == 9) else begin
            $display("Mismatch write burst count: expected %h actual %h", 9, log_aw_addr.size());
            burst_errs++;
        end
        compare_memory();

        $display("errors: data=%0d burst=%0d reg=%0d", data_errs, burst_errs, reg_errs);
        if (data_errs + burst_errs + reg_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/memcpy_pkg.sv
rtl/memcpy_regs.sv
rtl/memcpy_job_select.sv
rtl/memcpy_burst_gen.sv
rtl/axi_rd_master.sv
rtl/axi_wr_master.sv
rtl/beat_fifo.sv
rtl/memcpy_kernel.sv
dv/memcpy_kernel_assert.sv
dv/memcpy_kernel_tb.sv

// File: rtl/axi_rd_master.sv
`timescale 1ns/10ps

module axi_rd_master import memcpy_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  burst_cmd_t i_cmd,
    input  logic       i_cmd_valid,
    input  logic       i_ar_ready,
    input  beat_t      i_r,
    input  logic       i_r_valid,
    input  logic       i_fifo_full,
    output logic       o_cmd_ready,
    output burst_cmd_t o_ar,
    output logic       o_ar_valid,
    output logic       o_r_ready,
    output logic       o_push,
    output beat_t      o_push_beat
);

    logic cmd_fire;

    // take a new command once the address slot is free or draining
    assign o_cmd_ready = !o_ar_valid || i_ar_ready;
    assign cmd_fire    = i_cmd_valid && o_cmd_ready;

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            o_ar <= i_cmd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ar_valid <= 1'b0;
        end else if (cmd_fire) begin
            o_ar_valid <= 1'b1;
        end else if (i_ar_ready) begin
            o_ar_valid <= 1'b0;
        end
    end

    // read data only moves while the fifo has room
    assign o_r_ready   = !i_fifo_full;
    assign o_push      = i_r_valid && !i_fifo_full;
    assign o_push_beat = i_r;

endmodule

// File: rtl/axi_wr_master.sv
`timescale 1ns/10ps

module axi_wr_master import memcpy_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_go,
    input  burst_cmd_t i_cmd,
    input  logic       i_cmd_valid,
    input  logic       i_last_issued,
    input  logic       i_aw_ready,
    input  logic       i_w_ready,
    input  logic       i_b_valid,
    input  logic       i_fifo_empty,
    input  beat_t      i_pop_beat,
    output logic       o_cmd_ready,
    output burst_cmd_t o_aw,
    output logic       o_aw_valid,
    output beat_t      o_w,
    output logic       o_w_valid,
    output logic       o_b_ready,
    output logic       o_pop,
    output logic       o_job_done
);

    logic [BLEN_W-1:0] lq [LQ_DEPTH];
    logic [LQ_AW:0]    lq_wr;
    logic [LQ_AW:0]    lq_rd;
    logic              lq_full;
    logic              lq_empty;
    logic              cmd_fire;
    logic              w_last;
    logic [BLEN_W-1:0] beat_cnt;
    logic [LEN_W-1:0]  issued_cnt;
    logic [LEN_W-1:0]  resp_cnt;
    logic [LEN_W-1:0]  resp_next;
    logic              job_fin;

    // queue of burst lengths waiting for data
    assign lq_empty = lq_wr == lq_rd;
    assign lq_full  = (lq_wr[LQ_AW] != lq_rd[LQ_AW]) &&
                      (lq_wr[LQ_AW-1:0] == lq_rd[LQ_AW-1:0]);

    assign o_cmd_ready = (!o_aw_valid || i_aw_ready) && !lq_full;
    assign cmd_fire    = i_cmd_valid && o_cmd_ready;

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            o_aw                   <= i_cmd;
            lq[lq_wr[LQ_AW-1:0]] <= i_cmd.len;
        end
    end

    // wlast comes from the beat counter, not the read side
    assign w_last    = beat_cnt == lq[lq_rd[LQ_AW-1:0]];
    assign o_w_valid = !lq_empty && !i_fifo_empty;
    assign o_w.data  = i_pop_beat.data;
    assign o_w.last  = w_last;
    assign o_pop     = o_w_valid && i_w_ready;
    assign o_b_ready = 1'b1;

    // done in the same cycle as the final response
    assign resp_next  = resp_cnt + LEN_W'(i_b_valid);
    assign o_job_done = i_last_issued && !job_fin && (resp_next == issued_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_aw_valid <= 1'b0;
            lq_wr      <= '0;
            lq_rd      <= '0;
            beat_cnt   <= '0;
            issued_cnt <= '0;
            resp_cnt   <= '0;
            job_fin    <= 1'b0;
        end else begin
            if (cmd_fire) begin
                o_aw_valid <= 1'b1;
                lq_wr      <= lq_wr + 1'b1;
            end else if (i_aw_ready) begin
                o_aw_valid <= 1'b0;
            end
            if (o_pop) begin
                if (w_last) begin
                    beat_cnt <= '0;
                    lq_rd    <= lq_rd + 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
            if (i_go) begin
                issued_cnt <= '0;
                resp_cnt   <= '0;
                job_fin    <= 1'b0;
            end else begin
                if (cmd_fire) begin
                    issued_cnt <= issued_cnt + 1'b1;
                end
                resp_cnt <= resp_next;
                if (o_job_done) begin
                    job_fin <= 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/beat_fifo.sv
`timescale 1ns/10ps

module beat_fifo import memcpy_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_push,
    input  beat_t i_push_beat,
    input  logic  i_pop,
    output beat_t o_pop_beat,
    output logic  o_full,
    output logic  o_empty
);

    beat_t            mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;

    // extra pointer bit tells full from empty
    assign o_empty = wr_ptr == rd_ptr;
    assign o_full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                     (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    // head word shows without a pop
    assign o_pop_beat = mem[rd_ptr[FIFO_AW-1:0]];

    always_ff @(posedge clk) begin
        if (i_push && !o_full) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= i_push_beat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_push && !o_full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop && !o_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: rtl/memcpy_burst_gen.sv
`timescale 1ns/10ps

module memcpy_burst_gen import memcpy_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_go,
    input  logic [ADDR_W-1:0] i_base,
    input  logic [LEN_W-1:0]  i_len,
    input  logic              i_cmd_ready,
    output burst_cmd_t        o_cmd,
    output logic              o_cmd_valid,
    output logic              o_last_issued
);

    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  beats_left;
    logic [LEN_W-1:0]  burst_beats;

    // full burst or the tail
    assign burst_beats = (beats_left > LEN_W'(MAX_BEATS)) ? LEN_W'(MAX_BEATS) : beats_left;

    assign o_cmd.addr = addr;
    assign o_cmd.len  = BLEN_W'(burst_beats - 1'b1);

    always_ff @(posedge clk) begin
        if (i_go) begin
            addr       <= i_base;
            beats_left <= i_len / BEAT_BYTES;
        end else if (o_cmd_valid && i_cmd_ready) begin
            addr       <= addr + ADDR_W'(burst_beats * BEAT_BYTES);
            beats_left <= beats_left - burst_beats;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_cmd_valid   <= 1'b0;
            o_last_issued <= 1'b0;
        end else if (i_go) begin
            o_cmd_valid   <= 1'b1;
            o_last_issued <= 1'b0;
        end else if (o_cmd_valid && i_cmd_ready && beats_left == burst_beats) begin
            // final command of the job taken
            o_cmd_valid   <= 1'b0;
            o_last_issued <= 1'b1;
        end
    end

endmodule

// File: rtl/memcpy_job_select.sv
`timescale 1ns/10ps

module memcpy_job_select import memcpy_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_run_mode,
    input  logic             i_start,
    input  logic [SYS_W-1:0] i_system_register,
    input  job_t             i_reg_job,
    input  logic             i_reg_start,
    input  logic             i_reg_done,
    input  logic             i_job_done,
    output job_t             o_job,
    output logic             o_go,
    output logic             o_complete
);

    logic                 sys_load;
    logic [SYS_CNT_W-1:0] sys_cnt_field;
    logic [SYS_CNT_W-1:0] cnt;
    logic                 sys_go;
    job_t                 sys_job;

    assign sys_load      = i_run_mode && i_start;
    assign sys_cnt_field = i_system_register[SYS_CNT_LSB +: SYS_CNT_W];

    always_ff @(posedge clk) begin
        if (sys_load) begin
            sys_job.src <= i_system_register[SYS_SRC_LSB +: ADDR_W];
            sys_job.dst <= i_system_register[SYS_DST_LSB +: ADDR_W];
            sys_job.len <= i_system_register[SYS_LEN_LSB +: LEN_W];
        end
    end

    // repeat counter, one job per count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            sys_go <= 1'b0;
        end else begin
            if (sys_load) begin
                cnt <= sys_cnt_field;
            end else if (i_job_done && cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
            // restart right after a done while jobs remain
            sys_go <= (sys_load && sys_cnt_field != '0) ||
                      (!sys_load && i_job_done && cnt > 1);
        end
    end

    assign o_job      = i_run_mode ? sys_job : i_reg_job;
    assign o_go       = i_run_mode ? sys_go : i_reg_start;
    assign o_complete = i_run_mode ? (cnt == '0) : i_reg_done;

endmodule

// File: rtl/memcpy_kernel.sv
`timescale 1ns/10ps

module memcpy_kernel import memcpy_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // register port
    input  reg_req_t              i_reg,
    output logic [REG_DATA_W-1:0] o_reg_rdata,
    // system start path
    input  logic                  i_run_mode,
    input  logic                  i_start,
    input  logic [SYS_W-1:0]      i_system_register,
    output logic                  o_complete,
    // host memory master
    output burst_cmd_t            o_ar,
    output logic                  o_ar_valid,
    input  logic                  i_ar_ready,
    input  beat_t                 i_r,
    input  logic                  i_r_valid,
    output logic                  o_r_ready,
    output burst_cmd_t            o_aw,
    output logic                  o_aw_valid,
    input  logic                  i_aw_ready,
    output beat_t                 o_w,
    output logic                  o_w_valid,
    input  logic                  i_w_ready,
    input  logic                  i_b_valid,
    output logic                  o_b_ready
);

    job_t       reg_job;
    logic       reg_start;
    logic       reg_done;
    job_t       job;
    logic       go;
    logic       job_done;
    burst_cmd_t rd_cmd;
    logic       rd_cmd_valid;
    logic       rd_cmd_ready;
    burst_cmd_t wr_cmd;
    logic       wr_cmd_valid;
    logic       wr_cmd_ready;
    logic       wr_last_issued;
    logic       push;
    beat_t      push_beat;
    logic       pop;
    beat_t      pop_beat;
    logic       fifo_full;
    logic       fifo_empty;

    memcpy_regs regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_reg       (i_reg),
        .i_job_done  (job_done),
        .o_reg_rdata (o_reg_rdata),
        .o_reg_job   (reg_job),
        .o_reg_start (reg_start),
        .o_reg_done  (reg_done)
    );

    memcpy_job_select job_select_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_run_mode        (i_run_mode),
        .i_start           (i_start),
        .i_system_register (i_system_register),
        .i_reg_job         (reg_job),
        .i_reg_start       (reg_start),
        .i_reg_done        (reg_done),
        .i_job_done        (job_done),
        .o_job             (job),
        .o_go              (go),
        .o_complete        (o_complete)
    );

    // read side only needs the command stream
    memcpy_burst_gen rd_burst_gen_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_go          (go),
        .i_base        (job.src),
        .i_len         (job.len),
        .i_cmd_ready   (rd_cmd_ready),
        .o_cmd         (rd_cmd),
        .o_cmd_valid   (rd_cmd_valid),
        .o_last_issued ()
    );

    memcpy_burst_gen wr_burst_gen_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_go          (go),
        .i_base        (job.dst),
        .i_len         (job.len),
        .i_cmd_ready   (wr_cmd_ready),
        .o_cmd         (wr_cmd),
        .o_cmd_valid   (wr_cmd_valid),
        .o_last_issued (wr_last_issued)
    );

    axi_rd_master rd_master_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cmd       (rd_cmd),
        .i_cmd_valid (rd_cmd_valid),
        .i_ar_ready  (i_ar_ready),
        .i_r         (i_r),
        .i_r_valid   (i_r_valid),
        .i_fifo_full (fifo_full),
        .o_cmd_ready (rd_cmd_ready),
        .o_ar        (o_ar),
        .o_ar_valid  (o_ar_valid),
        .o_r_ready   (o_r_ready),
        .o_push      (push),
        .o_push_beat (push_beat)
    );

    beat_fifo beat_fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_push      (push),
        .i_push_beat (push_beat),
        .i_pop       (pop),
        .o_pop_beat  (pop_beat),
        .o_full      (fifo_full),
        .o_empty     (fifo_empty)
    );

    axi_wr_master wr_master_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_go          (go),
        .i_cmd         (wr_cmd),
        .i_cmd_valid   (wr_cmd_valid),
        .i_last_issued (wr_last_issued),
        .i_aw_ready    (i_aw_ready),
        .i_w_ready     (i_w_ready),
        .i_b_valid     (i_b_valid),
        .i_fifo_empty  (fifo_empty),
        .i_pop_beat    (pop_beat),
        .o_cmd_ready   (wr_cmd_ready),
        .o_aw          (o_aw),
        .o_aw_valid    (o_aw_valid),
        .o_w           (o_w),
        .o_w_valid     (o_w_valid),
        .o_b_ready     (o_b_ready),
        .o_pop         (pop),
        .o_job_done    (job_done)
    );

endmodule

// File: rtl/memcpy_pkg.sv
package memcpy_pkg;

    // host side widths
    localparam int ADDR_W     = 64;
    localparam int DATA_W     = 64;
    localparam int BEAT_BYTES = 8;
    localparam int LEN_W      = 32;

    // burst and buffering
    localparam int MAX_BEATS  = 16;
    localparam int BLEN_W     = 8;
    localparam int FIFO_DEPTH = 32;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int LQ_DEPTH   = 4;
    localparam int LQ_AW      = $clog2(LQ_DEPTH);

    // register port
    localparam int REG_ADDR_W = 3;
    localparam int REG_DATA_W = 32;

    localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 3'd0;
    localparam logic [REG_ADDR_W-1:0] REG_STATUS = 3'd1;
    localparam logic [REG_ADDR_W-1:0] REG_SRC_LO = 3'd2;
    localparam logic [REG_ADDR_W-1:0] REG_SRC_HI = 3'd3;
    localparam logic [REG_ADDR_W-1:0] REG_DST_LO = 3'd4;
    localparam logic [REG_ADDR_W-1:0] REG_DST_HI = 3'd5;
    localparam logic [REG_ADDR_W-1:0] REG_LEN    = 3'd6;

    // fields of the 512-bit system word
    localparam int SYS_W       = 512;
    localparam int SYS_LEN_LSB = 32;
    localparam int SYS_SRC_LSB = 64;
    localparam int SYS_DST_LSB = 128;
    localparam int SYS_CNT_LSB = 288;
    localparam int SYS_CNT_W   = 32;

    typedef struct packed {
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [LEN_W-1:0]  len;
    } job_t;

    // len holds beats minus one
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BLEN_W-1:0] len;
    } burst_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } beat_t;

    typedef struct packed {
        logic                  wr;
        logic                  rd;
        logic [REG_ADDR_W-1:0] idx;
        logic [REG_DATA_W-1:0] wdata;
    } reg_req_t;

endpackage

// File: rtl/memcpy_regs.sv
`timescale 1ns/10ps

module memcpy_regs import memcpy_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  reg_req_t              i_reg,
    input  logic                  i_job_done,
    output logic [REG_DATA_W-1:0] o_reg_rdata,
    output job_t                  o_reg_job,
    output logic                  o_reg_start,
    output logic                  o_reg_done
);

    logic ctrl_wr;
    logic busy;

    assign ctrl_wr = i_reg.wr && (i_reg.idx == REG_CTRL) && i_reg.wdata[0];

    // job registers
    always_ff @(posedge clk) begin
        if (i_reg.wr) begin
            case (i_reg.idx)
                REG_SRC_LO: o_reg_job.src[31:0]  <= i_reg.wdata;
                REG_SRC_HI: o_reg_job.src[63:32] <= i_reg.wdata;
                REG_DST_LO: o_reg_job.dst[31:0]  <= i_reg.wdata;
                REG_DST_HI: o_reg_job.dst[63:32] <= i_reg.wdata;
                REG_LEN:    o_reg_job.len        <= i_reg.wdata;
                default: ;
            endcase
        end
    end

    // start pulse and status
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_reg_start <= 1'b0;
            busy        <= 1'b0;
            o_reg_done  <= 1'b0;
        end else begin
            o_reg_start <= ctrl_wr;
            if (ctrl_wr) begin
                busy       <= 1'b1;
                o_reg_done <= 1'b0;
            end else if (i_job_done) begin
                busy       <= 1'b0;
                o_reg_done <= 1'b1;
            end
        end
    end

    // read data one cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_reg_rdata <= '0;
        end else if (i_reg.rd) begin
            case (i_reg.idx)
                REG_STATUS: o_reg_rdata <= {30'd0, busy, o_reg_done};
                REG_SRC_LO: o_reg_rdata <= o_reg_job.src[31:0];
                REG_SRC_HI: o_reg_rdata <= o_reg_job.src[63:32];
                REG_DST_LO: o_reg_rdata <= o_reg_job.dst[31:0];
                REG_DST_HI: o_reg_rdata <= o_reg_job.dst[63:32];
                REG_LEN:    o_reg_rdata <= o_reg_job.len;
                default:    o_reg_rdata <= '0;
            endcase
        end
    end

endmodule
